// File: common/isa_pkg.sv
package isa_pkg;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;

    // major opcodes of the integer ALU subset
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;

    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SRL_SRA = 3'b101;

    localparam logic [6:0] FUNCT7_ALT = 7'b0100000; // sub, sra, srai

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3_t    funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        funct3_t     funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0] imm; // bits 31:12 of the result
        logic [4:0]  rd;
        opcode_t     opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        u_fmt_t u;
    } instr_u;

endpackage

// File: common/core_pkg.sv
package core_pkg;

    localparam int XLEN      = 32;
    localparam int N_ARF     = 32;
    localparam int ROB_DEPTH = 16;

    typedef logic [$clog2(N_ARF)-1:0]     arf_id_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_id_t;
    typedef logic [XLEN-1:0]              reg_data_t;

endpackage

// File: rtl/decode.sv
`timescale 1ns/1ps

module decode (
    input  isa_pkg::instr_u     instr,
    output core_pkg::arf_id_t   rs1,
    output core_pkg::arf_id_t   rs2,
    output logic                rs1_valid,
    output logic                rs2_valid,
    output core_pkg::arf_id_t   rd,
    output logic                rd_valid,
    output isa_pkg::funct3_t    funct3,
    output core_pkg::reg_data_t imm,
    output logic                is_r_type,
    output logic                is_i_type,
    output logic                is_u_type,
    output logic                is_sub,
    output logic                is_sra_srai,
    output logic                is_lui
);
    import isa_pkg::*;
    import core_pkg::*;

    opcode_t opcode;
    logic    alt; // funct7 says sub / arithmetic shift

    assign opcode = instr.r.opcode;
    assign alt    = (instr.r.funct7 == FUNCT7_ALT);

    assign is_r_type = (opcode == OPC_OP);
    assign is_i_type = (opcode == OPC_OP_IMM);
    assign is_lui    = (opcode == OPC_LUI);
    assign is_u_type = is_lui || (opcode == OPC_AUIPC);

    // register fields sit in the same place for every format
    assign rs1    = instr.r.rs1;
    assign rs2    = instr.r.rs2;
    assign rd     = instr.r.rd;
    assign funct3 = instr.r.funct3;

    assign rs1_valid = is_r_type || is_i_type;
    assign rs2_valid = is_r_type;
    assign rd_valid  = (is_r_type || is_i_type || is_u_type) && (rd != '0); // x0 never renamed

    assign is_sub      = is_r_type && alt && (funct3 == F3_ADD_SUB);
    assign is_sra_srai = (is_r_type || is_i_type) && alt && (funct3 == F3_SRL_SRA);

    always_comb begin
        imm = '0;
        if (is_i_type) begin
            imm = {{(XLEN-12){instr.i.imm[11]}}, instr.i.imm}; // sign extend
        end else if (is_u_type) begin
            imm = {instr.u.imm, 12'b0};
        end
    end

endmodule

// File: rename/rename_table.sv
`timescale 1ns/1ps

module rename_table (
    input  logic              clk,
    input  logic              rst,
    input  core_pkg::arf_id_t rs1,
    input  core_pkg::arf_id_t rs2,
    output logic              rs1_spec,
    output logic              rs2_spec,
    output core_pkg::rob_id_t rs1_tag,
    output core_pkg::rob_id_t rs2_tag,
    input  logic              rename_en,
    input  core_pkg::arf_id_t rename_rd,
    input  core_pkg::rob_id_t rename_tag,
    input  logic              retire_valid,
    input  core_pkg::arf_id_t retire_arf_id,
    input  core_pkg::rob_id_t retire_tag
);
    import core_pkg::*;

    logic    [N_ARF-1:0] spec_q;    // 1 = value lives in the ROB
    rob_id_t             tag_q [N_ARF];
    logic                retire_clear;

    assign rs1_spec = spec_q[rs1];
    assign rs2_spec = spec_q[rs2];
    assign rs1_tag  = tag_q[rs1];
    assign rs2_tag  = tag_q[rs2];

    // only the newest producer of a register may clear its bit
    assign retire_clear = retire_valid && (tag_q[retire_arf_id] == retire_tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            spec_q <= '0;
        end else begin
            if (retire_clear) begin
                spec_q[retire_arf_id] <= 1'b0;
            end
            if (rename_en) begin
                spec_q[rename_rd] <= 1'b1; // rename wins over a same-cycle clear
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rename_en) begin
            tag_q[rename_rd] <= rename_tag;
        end
    end

endmodule

// File: rob/rob.sv
`timescale 1ns/1ps

module rob (
    input  logic                clk,
    input  logic                rst,
    input  logic                alloc_en,
    input  logic                alloc_dst_valid,
    input  core_pkg::arf_id_t   alloc_arf_id,
    output core_pkg::rob_id_t   alloc_tag,
    output logic                full,
    input  logic                wb_valid,
    input  core_pkg::rob_id_t   wb_tag,
    input  core_pkg::reg_data_t wb_data,
    input  core_pkg::rob_id_t   src1_tag,
    input  core_pkg::rob_id_t   src2_tag,
    output logic                src1_done,
    output logic                src2_done,
    output core_pkg::reg_data_t src1_data,
    output core_pkg::reg_data_t src2_data,
    output logic                commit_valid,
    output logic                commit_dst_valid,
    output core_pkg::arf_id_t   commit_arf_id,
    output core_pkg::rob_id_t   commit_tag,
    output core_pkg::reg_data_t commit_data
);
    import core_pkg::*;

    rob_id_t                    head_q;
    rob_id_t                    tail_q;
    logic [$clog2(ROB_DEPTH):0] count_q;

    logic [ROB_DEPTH-1:0] busy_q;
    logic [ROB_DEPTH-1:0] done_q;
    logic [ROB_DEPTH-1:0] dst_valid_q;
    arf_id_t              arf_id_q [ROB_DEPTH];
    reg_data_t            data_q   [ROB_DEPTH];

    assign alloc_tag = tail_q;
    assign full      = (count_q == ROB_DEPTH);

    // source lookups for dispatch
    assign src1_done = busy_q[src1_tag] && done_q[src1_tag];
    assign src2_done = busy_q[src2_tag] && done_q[src2_tag];
    assign src1_data = data_q[src1_tag];
    assign src2_data = data_q[src2_tag];

    assign commit_valid     = busy_q[head_q] && done_q[head_q];
    assign commit_dst_valid = commit_valid && dst_valid_q[head_q];
    assign commit_arf_id    = arf_id_q[head_q];
    assign commit_tag       = head_q;
    assign commit_data      = data_q[head_q];

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            busy_q  <= '0;
            done_q  <= '0;
        end else begin
            if (alloc_en) begin
                busy_q[tail_q] <= 1'b1;
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1; // wraps at ROB_DEPTH
            end
            if (wb_valid) begin
                done_q[wb_tag] <= 1'b1;
            end
            if (commit_valid) begin
                busy_q[head_q] <= 1'b0; // slot free at this edge
                head_q         <= head_q + 1'b1;
            end
            case ({alloc_en, commit_valid})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            dst_valid_q[tail_q] <= alloc_dst_valid;
            arf_id_q[tail_q]    <= alloc_arf_id;
        end
        if (wb_valid) begin
            data_q[wb_tag] <= wb_data;
        end
    end

endmodule

// File: rtl/arf.sv
`timescale 1ns/1ps

module arf (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::arf_id_t   rd_addr1,
    input  core_pkg::arf_id_t   rd_addr2,
    output core_pkg::reg_data_t rd_data1,
    output core_pkg::reg_data_t rd_data2,
    input  logic                wr_en,
    input  core_pkg::arf_id_t   wr_addr,
    input  core_pkg::reg_data_t wr_data
);
    import core_pkg::*;

    reg_data_t regs_q [N_ARF];

    assign rd_data1 = regs_q[rd_addr1];
    assign rd_data2 = regs_q[rd_addr2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < N_ARF; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin // x0 stays zero
            regs_q[wr_addr] <= wr_data;
        end
    end

endmodule

// File: rtl/operand_select.sv
`timescale 1ns/1ps

module operand_select (
    input  logic                src_valid,
    input  logic                spec,
    input  core_pkg::rob_id_t   tag,
    input  core_pkg::reg_data_t arf_data,
    input  logic                rob_done,
    input  core_pkg::reg_data_t rob_data,
    input  logic                bcast_valid,
    input  core_pkg::rob_id_t   bcast_tag,
    input  core_pkg::reg_data_t bcast_data,
    output logic                ready,
    output core_pkg::reg_data_t data
);

    always_comb begin
        ready = 1'b0;
        data  = '0;
        if (!src_valid) begin
            ready = 1'b1; // no such operand
        end else if (!spec) begin
            ready = 1'b1;
            data  = arf_data;
        end else if (bcast_valid && (bcast_tag == tag)) begin
            ready = 1'b1; // producer finishes this cycle
            data  = bcast_data;
        end else if (rob_done) begin
            ready = 1'b1;
            data  = rob_data;
        end
    end

endmodule

// File: rtl/dispatch.sv
`timescale 1ns/1ps

module dispatch (
    input  logic                clk,
    input  logic                rst,
    input  logic                ififo_valid,
    input  isa_pkg::instr_u     ififo_instr,
    input  core_pkg::reg_data_t ififo_pc,
    output logic                ififo_ready,
    input  logic                iiq_ready,
    output logic                iiq_valid,
    output logic                iiq_src1_valid,
    output core_pkg::rob_id_t   iiq_src1_tag,
    output logic                iiq_src1_ready,
    output core_pkg::reg_data_t iiq_src1_data,
    output logic                iiq_src2_valid,
    output core_pkg::rob_id_t   iiq_src2_tag,
    output logic                iiq_src2_ready,
    output core_pkg::reg_data_t iiq_src2_data,
    output logic                iiq_dst_valid,
    output core_pkg::rob_id_t   iiq_rob_id,
    output core_pkg::reg_data_t iiq_imm,
    output core_pkg::reg_data_t iiq_pc,
    output isa_pkg::funct3_t    iiq_funct3,
    output logic                iiq_is_r_type,
    output logic                iiq_is_i_type,
    output logic                iiq_is_u_type,
    output logic                iiq_is_sub,
    output logic                iiq_is_sra_srai,
    output logic                iiq_is_lui,
    input  logic                alu_wb_valid,
    input  core_pkg::rob_id_t   alu_wb_rob_id,
    input  core_pkg::reg_data_t alu_wb_data,
    output logic                commit_valid,
    output logic                commit_dst_valid,
    output core_pkg::arf_id_t   commit_arf_id,
    output core_pkg::reg_data_t commit_data
);
    import core_pkg::*;

    arf_id_t   rs1;
    arf_id_t   rs2;
    arf_id_t   rd;
    logic      rs1_spec;
    logic      rs2_spec;
    rob_id_t   rob_tag; // slot given to the instruction on the ports
    rob_id_t   commit_tag;
    logic      rob_full;
    logic      go;      // the instruction leaves the FIFO this cycle
    logic      src1_done;
    logic      src2_done;
    reg_data_t rob_data1;
    reg_data_t rob_data2;
    reg_data_t arf_data1;
    reg_data_t arf_data2;

    assign go          = ififo_valid && !rob_full && iiq_ready;
    assign ififo_ready = go;
    assign iiq_valid   = go;
    assign iiq_rob_id  = rob_tag;
    assign iiq_pc      = ififo_pc;

    decode decode0 (
        .instr(ififo_instr),
        .rs1(rs1), .rs2(rs2),
        .rs1_valid(iiq_src1_valid), .rs2_valid(iiq_src2_valid),
        .rd(rd), .rd_valid(iiq_dst_valid),
        .funct3(iiq_funct3), .imm(iiq_imm),
        .is_r_type(iiq_is_r_type), .is_i_type(iiq_is_i_type), .is_u_type(iiq_is_u_type),
        .is_sub(iiq_is_sub), .is_sra_srai(iiq_is_sra_srai), .is_lui(iiq_is_lui)
    );

    rename_table rename_table0 (
        .clk(clk), .rst(rst),
        .rs1(rs1), .rs2(rs2),
        .rs1_spec(rs1_spec), .rs2_spec(rs2_spec),
        .rs1_tag(iiq_src1_tag), .rs2_tag(iiq_src2_tag),
        .rename_en(go && iiq_dst_valid), .rename_rd(rd), .rename_tag(rob_tag),
        .retire_valid(commit_dst_valid), // already qualified by commit_valid
        .retire_arf_id(commit_arf_id), .retire_tag(commit_tag)
    );

    rob rob0 (
        .clk(clk), .rst(rst),
        .alloc_en(go), .alloc_dst_valid(iiq_dst_valid), .alloc_arf_id(rd),
        .alloc_tag(rob_tag), .full(rob_full),
        .wb_valid(alu_wb_valid), .wb_tag(alu_wb_rob_id), .wb_data(alu_wb_data),
        .src1_tag(iiq_src1_tag), .src2_tag(iiq_src2_tag),
        .src1_done(src1_done), .src2_done(src2_done),
        .src1_data(rob_data1), .src2_data(rob_data2),
        .commit_valid(commit_valid), .commit_dst_valid(commit_dst_valid),
        .commit_arf_id(commit_arf_id), .commit_tag(commit_tag), .commit_data(commit_data)
    );

    arf arf0 (
        .clk(clk), .rst(rst),
        .rd_addr1(rs1), .rd_addr2(rs2),
        .rd_data1(arf_data1), .rd_data2(arf_data2),
        .wr_en(commit_dst_valid), .wr_addr(commit_arf_id), .wr_data(commit_data)
    );

    operand_select src1_sel (
        .src_valid(iiq_src1_valid), .spec(rs1_spec), .tag(iiq_src1_tag),
        .arf_data(arf_data1), .rob_done(src1_done), .rob_data(rob_data1),
        .bcast_valid(alu_wb_valid), .bcast_tag(alu_wb_rob_id), .bcast_data(alu_wb_data),
        .ready(iiq_src1_ready), .data(iiq_src1_data)
    );

    operand_select src2_sel (
        .src_valid(iiq_src2_valid), .spec(rs2_spec), .tag(iiq_src2_tag),
        .arf_data(arf_data2), .rob_done(src2_done), .rob_data(rob_data2),
        .bcast_valid(alu_wb_valid), .bcast_tag(alu_wb_rob_id), .bcast_data(alu_wb_data),
        .ready(iiq_src2_ready), .data(iiq_src2_data)
    );

endmodule

// File: dv/dispatch_checker.sv
`timescale 1ns/1ps

module dispatch_checker #(
    parameter int N_LINES = 16,
    parameter int N_TOTAL = 48
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        ififo_valid,
    input  logic        ififo_ready,
    input  logic        iiq_ready,
    input  logic        iiq_valid,
    input  logic        iiq_src1_valid,
    input  logic        iiq_src1_ready,
    input  logic [31:0] iiq_src1_data,
    input  logic        iiq_src2_valid,
    input  logic        iiq_src2_ready,
    input  logic [31:0] iiq_src2_data,
    input  logic        iiq_dst_valid,
    input  logic        iiq_is_r_type,
    input  logic        iiq_is_i_type,
    input  logic        commit_valid,
    input  logic        commit_dst_valid,
    input  logic [4:0]  commit_arf_id,
    input  logic [31:0] commit_data,
    input  int          phase,
    input  logic        done,
    output int          errors
);
    import core_pkg::*;

    logic [31:0] vec  [2*N_LINES];
    logic [31:0] gold [32]; // register state after every line dispatched so far
    int          n_disp = 0;
    int          n_commit = 0;
    int          stall_cycles = 0;
    int          err_count = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          last_phase = 0;
    logic        done_seen = 1'b0;

    assign errors = err_count;

    initial begin
        $readmemh("dv/dispatch_vectors.hex", vec);
    end

    task automatic wrong_value(input string msg);
        $display("FAILED t=%0t: %s", $time, msg);
        err_count++;
        test_errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("problem: %s", msg);
        err_count++;
        test_errors++;
    endtask

    function automatic string test_name(input int ph);
        case (ph)
            0:       return "reset";
            1:       return "random traffic";
            default: return "rob full";
        endcase
    endfunction

    task automatic close_test(input int ph);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %s: %s, %0d errors", test_name(ph), test_errors == 0 ? "ok" : "bad",
                 test_errors);
        test_errors = 0;
    endtask

    task automatic check_source(input int line, input int n, input logic present,
            input logic [4:0] rs, input logic valid, input logic rdy, input logic [31:0] data);
        if (valid != present) begin
            wrong_value($sformatf("line %0d src%0d valid is %0b", line, n, valid));
        end else if (!present || rs == '0) begin
            if (!rdy || data != '0) begin
                wrong_value($sformatf("line %0d src%0d should be ready with zero", line, n));
            end
        end else if (rdy && data != gold[rs]) begin
            wrong_value($sformatf("line %0d src%0d x%0d is %h, expected %h",
                                  line, n, rs, data, gold[rs]));
        end
    endtask

    always @(posedge clk) begin
        int          line;
        logic [31:0] w;
        logic        is_op;
        logic        is_imm;
        if (phase != last_phase) begin
            close_test(last_phase);
            last_phase = phase;
        end
        if (rst) begin
            for (int k = 0; k < 32; k++) begin
                gold[k] = '0;
            end
        end
        if ((rst || phase == 0) && (ififo_ready || iiq_valid || commit_valid)) begin
            wrong_value("handshake or commit active around reset");
        end
        if (ififo_ready != iiq_valid) begin
            wrong_value("ififo_ready and iiq_valid differ");
        end
        if (!iiq_ready && iiq_valid) begin
            wrong_value("dispatch while iiq_ready is low");
        end
        if (ififo_valid && iiq_ready && !ififo_ready) begin
            stall_cycles++; // only a full ROB may hold the instruction back
            if (n_disp - n_commit != ROB_DEPTH) begin
                wrong_value($sformatf("stall with %0d in flight", n_disp - n_commit));
            end
        end
        if (iiq_valid) begin
            line   = n_disp % N_LINES;
            w      = vec[2*line];
            is_op  = (w[6:0] == 7'b0110011);
            is_imm = (w[6:0] == 7'b0010011);
            check_source(line, 1, is_op || is_imm, w[19:15], iiq_src1_valid, iiq_src1_ready,
                         iiq_src1_data);
            check_source(line, 2, is_op, w[24:20], iiq_src2_valid, iiq_src2_ready,
                         iiq_src2_data);
            if (iiq_dst_valid != (w[11:7] != '0)) begin
                wrong_value($sformatf("line %0d dst valid is %0b", line, iiq_dst_valid));
            end
            if (iiq_is_r_type != is_op || iiq_is_i_type != is_imm) begin
                wrong_value($sformatf("line %0d type flags r=%0b i=%0b", line,
                                      iiq_is_r_type, iiq_is_i_type));
            end
            if (w[11:7] != '0) begin
                gold[w[11:7]] = vec[2*line+1];
            end
            n_disp++;
        end
        if (commit_valid) begin
            line = n_commit % N_LINES;
            w    = vec[2*line];
            if (commit_dst_valid != (w[11:7] != '0)) begin
                wrong_value($sformatf("line %0d commit_dst_valid is %0b", line, commit_dst_valid));
            end else if (commit_dst_valid && commit_arf_id != w[11:7]) begin
                wrong_value($sformatf("line %0d commits to x%0d", line, commit_arf_id));
            end
            if (commit_data != vec[2*line+1]) begin
                wrong_value($sformatf("line %0d commit data %h, expected %h",
                                      line, commit_data, vec[2*line+1]));
            end
            n_commit++;
        end
        if (done && !done_seen) begin
            done_seen = 1'b1;
            if (n_disp != N_TOTAL || n_commit != N_TOTAL) begin
                wrong_value($sformatf("%0d dispatches and %0d commits, expected %0d",
                                      n_disp, n_commit, N_TOTAL));
            end
            if (stall_cycles == 0) begin
                report_problem("the ROB never filled up, so dispatch was never held back");
            end
            close_test(phase);
            $display("tests run %0d, tests failed %0d, errors %0d",
                     tests_run, tests_failed, err_count);
        end
    end

endmodule

// File: dv/dispatch_tb.sv
`timescale 1ns/1ps

module dispatch_tb;
    import core_pkg::*;

    localparam int N_LINES    = 16;
    localparam int N_TOTAL    = 3 * N_LINES; // random pass then ROB full pass and refill
    localparam int WAIT_LIMIT = 300;         // cycles

    logic        clk = 1'b0;
    logic        rst;
    logic        ififo_valid;
    logic [31:0] ififo_instr;
    logic [31:0] ififo_pc;
    logic        ififo_ready;
    logic        iiq_ready = 1'b1;
    logic        iiq_valid;
    logic        iiq_src1_valid, iiq_src1_ready, iiq_src2_valid, iiq_src2_ready;
    rob_id_t     iiq_src1_tag, iiq_src2_tag, iiq_rob_id;
    logic [31:0] iiq_src1_data, iiq_src2_data, iiq_imm, iiq_pc;
    logic        iiq_dst_valid;
    logic [2:0]  iiq_funct3;
    logic        iiq_is_r_type, iiq_is_i_type, iiq_is_u_type;
    logic        iiq_is_sub, iiq_is_sra_srai, iiq_is_lui;
    logic        alu_wb_valid = 1'b0;
    rob_id_t     alu_wb_rob_id = '0;
    logic [31:0] alu_wb_data = '0;
    logic        commit_valid, commit_dst_valid;
    logic [4:0]  commit_arf_id;
    logic [31:0] commit_data;

    logic [31:0] vec [2*N_LINES]; // instruction word and expected rd value pairs
    int          seed = 32'h9f5a;
    int          phase;
    logic        done;
    logic        hold;  // ALU model keeps every result back
    logic        bp_en; // random iiq_ready
    int          errors;
    int          disp_count = 0;
    int          commit_count = 0;

    // issue-queue model with one slot per ROB tag
    logic [ROB_DEPTH-1:0] pend = '0;
    logic [ROB_DEPTH-1:0] s1_rdy, s2_rdy;
    rob_id_t              s1_tag [ROB_DEPTH];
    rob_id_t              s2_tag [ROB_DEPTH];
    logic [31:0]          s1_val [ROB_DEPTH];
    logic [31:0]          s2_val [ROB_DEPTH];
    logic [31:0]          imm_q  [ROB_DEPTH];
    logic [31:0]          pc_q   [ROB_DEPTH];
    logic [2:0]           f3_q   [ROB_DEPTH];
    logic [5:0]           fl_q   [ROB_DEPTH]; // {r, i, u, sub, sra, lui}
    int                   delay  [ROB_DEPTH];
    logic                 nxt_wb_valid = 1'b0;
    rob_id_t              nxt_wb_tag = '0;
    logic [31:0]          nxt_wb_data = '0;
    logic                 nxt_iiq_ready = 1'b1;

    always #4 clk = ~clk;

    dispatch dut0 (
        .clk(clk), .rst(rst),
        .ififo_valid(ififo_valid), .ififo_instr(ififo_instr), .ififo_pc(ififo_pc),
        .ififo_ready(ififo_ready), .iiq_ready(iiq_ready), .iiq_valid(iiq_valid),
        .iiq_src1_valid(iiq_src1_valid), .iiq_src1_tag(iiq_src1_tag),
        .iiq_src1_ready(iiq_src1_ready), .iiq_src1_data(iiq_src1_data),
        .iiq_src2_valid(iiq_src2_valid), .iiq_src2_tag(iiq_src2_tag),
        .iiq_src2_ready(iiq_src2_ready), .iiq_src2_data(iiq_src2_data),
        .iiq_dst_valid(iiq_dst_valid), .iiq_rob_id(iiq_rob_id), .iiq_imm(iiq_imm),
        .iiq_pc(iiq_pc), .iiq_funct3(iiq_funct3),
        .iiq_is_r_type(iiq_is_r_type), .iiq_is_i_type(iiq_is_i_type),
        .iiq_is_u_type(iiq_is_u_type), .iiq_is_sub(iiq_is_sub),
        .iiq_is_sra_srai(iiq_is_sra_srai), .iiq_is_lui(iiq_is_lui),
        .alu_wb_valid(alu_wb_valid), .alu_wb_rob_id(alu_wb_rob_id), .alu_wb_data(alu_wb_data),
        .commit_valid(commit_valid), .commit_dst_valid(commit_dst_valid),
        .commit_arf_id(commit_arf_id), .commit_data(commit_data)
    );

    dispatch_checker #(.N_LINES(N_LINES), .N_TOTAL(N_TOTAL)) monitor0 (
        .clk(clk), .rst(rst),
        .ififo_valid(ififo_valid), .ififo_ready(ififo_ready),
        .iiq_ready(iiq_ready), .iiq_valid(iiq_valid),
        .iiq_src1_valid(iiq_src1_valid), .iiq_src1_ready(iiq_src1_ready),
        .iiq_src1_data(iiq_src1_data),
        .iiq_src2_valid(iiq_src2_valid), .iiq_src2_ready(iiq_src2_ready),
        .iiq_src2_data(iiq_src2_data),
        .iiq_dst_valid(iiq_dst_valid), .iiq_is_r_type(iiq_is_r_type),
        .iiq_is_i_type(iiq_is_i_type),
        .commit_valid(commit_valid), .commit_dst_valid(commit_dst_valid),
        .commit_arf_id(commit_arf_id), .commit_data(commit_data),
        .phase(phase), .done(done), .errors(errors)
    );

    function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic [5:0] fl,
            input logic [31:0] a, input logic [31:0] rb, input logic [31:0] imm,
            input logic [31:0] pc);
        logic [31:0]        b;
        logic signed [31:0] sa;
        b  = fl[4] ? imm : rb; // immediate ops take imm as second operand
        sa = a;
        if (fl[3]) begin
            return fl[0] ? imm : pc + imm;
        end
        case (f3)
            3'd0: return fl[2] ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, sa < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (fl[1]) begin
                    return sa >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // samples the DUT like its own flops and plans the next write-back
    always @(posedge clk) begin
        int   r;
        logic found;
        if (rst) begin
            pend = '0;
            nxt_wb_valid = 1'b0;
        end else begin
            for (int k = 0; k < ROB_DEPTH; k++) begin
                if (alu_wb_valid && pend[k] && !s1_rdy[k] && s1_tag[k] == alu_wb_rob_id) begin
                    s1_rdy[k] = 1'b1;
                    s1_val[k] = alu_wb_data;
                end
                if (alu_wb_valid && pend[k] && !s2_rdy[k] && s2_tag[k] == alu_wb_rob_id) begin
                    s2_rdy[k] = 1'b1;
                    s2_val[k] = alu_wb_data;
                end
            end
            if (iiq_valid) begin
                pend[iiq_rob_id]   = 1'b1;
                s1_rdy[iiq_rob_id] = iiq_src1_ready;
                s1_val[iiq_rob_id] = iiq_src1_data;
                s1_tag[iiq_rob_id] = iiq_src1_tag;
                s2_rdy[iiq_rob_id] = iiq_src2_ready;
                s2_val[iiq_rob_id] = iiq_src2_data;
                s2_tag[iiq_rob_id] = iiq_src2_tag;
                imm_q[iiq_rob_id]  = iiq_imm;
                pc_q[iiq_rob_id]   = iiq_pc;
                f3_q[iiq_rob_id]   = iiq_funct3;
                fl_q[iiq_rob_id]   = {iiq_is_r_type, iiq_is_i_type, iiq_is_u_type,
                                      iiq_is_sub, iiq_is_sra_srai, iiq_is_lui};
                r = $random(seed);
                delay[iiq_rob_id] = $unsigned(r) % 6; // 0 to 5 cycles
                disp_count++;
            end
            if (commit_valid) begin
                commit_count++;
            end
            nxt_wb_valid = 1'b0;
            found = 1'b0;
            for (int k = 0; k < ROB_DEPTH; k++) begin
                if (pend[k] && s1_rdy[k] && s2_rdy[k]) begin
                    if (!found && !hold && delay[k] == 0) begin
                        found = 1'b1;
                        pend[k] = 1'b0;
                        nxt_wb_valid = 1'b1;
                        nxt_wb_tag = k[3:0];
                        nxt_wb_data = alu_result(f3_q[k], fl_q[k], s1_val[k], s2_val[k],
                                                 imm_q[k], pc_q[k]);
                    end else if (delay[k] > 0) begin
                        delay[k]--;
                    end
                end
            end
        end
        r = $random(seed);
        nxt_iiq_ready = !bp_en || (r[1:0] != 2'b00); // low about a quarter of the time
    end

    always @(negedge clk) begin
        alu_wb_valid  = nxt_wb_valid;
        alu_wb_rob_id = nxt_wb_tag;
        alu_wb_data   = nxt_wb_data;
        iiq_ready     = nxt_iiq_ready;
    end

    task automatic give_up(input string what);
        $display("timeout: %s", what);
        $display("Checks failed");
        $finish;
    endtask

    task automatic wait_dispatches(input int target);
        int cycles;
        cycles = 0;
        while (disp_count < target && cycles <= WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (disp_count < target) begin
            give_up($sformatf("instruction %0d was never dispatched", target - 1));
        end
    endtask

    task automatic wait_commits(input int target);
        int cycles;
        cycles = 0;
        while (commit_count < target && cycles <= WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (commit_count < target) begin
            give_up($sformatf("only %0d of %0d instructions committed", commit_count, target));
        end
    endtask

    task automatic present(input int idx);
        ififo_valid = 1'b1;
        ififo_instr = vec[2*(idx % N_LINES)];
        ififo_pc    = 4 * (idx % N_LINES); // pc restarts with each pass of the program
    endtask

    task automatic feed(input int first, input int last);
        for (int idx = first; idx <= last; idx++) begin
            present(idx);
            wait_dispatches(idx + 1);
        end
    endtask

    initial begin
        rst = 1'b1;
        ififo_valid = 1'b0;
        ififo_instr = '0;
        ififo_pc = '0;
        phase = 0;
        done = 1'b0;
        hold = 1'b0;
        bp_en = 1'b0;
        $readmemh("dv/dispatch_vectors.hex", vec);
        repeat (5) @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);

        phase = 1; // random back-pressure and write-back order
        bp_en = 1'b1;
        feed(0, N_LINES - 1);
        ififo_valid = 1'b0;
        wait_commits(N_LINES);

        phase = 2; // ROB fills while the ALU holds its results
        bp_en = 1'b0;
        hold = 1'b1;
        feed(N_LINES, 2*N_LINES - 1);
        present(2*N_LINES);
        repeat (20) @(negedge clk); // observation window with a full ROB
        hold = 1'b0;
        wait_dispatches(2*N_LINES + 1);
        feed(2*N_LINES + 1, N_TOTAL - 1);
        ififo_valid = 1'b0;
        wait_commits(N_TOTAL);

        done = 1'b1;
        repeat (2) @(negedge clk);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: dv/dispatch_vectors.hex
// instruction word, then expected rd value (the ALU result); pc is 4 * line
00500093 00000005
FFD00113 FFFFFFFD
002081B3 00000002
40208233 00000008
123452B7 12345000
00001317 00001014
401153B3 FFFFFFFF
00415413 0FFFFFFF
0041C4B3 0000000A
00112533 00000001
001135B3 00000000
// rd is x0 here
00708013 0000000C
00409633 00000500
000660B3 00000500
0F00F693 00000000
00108733 00000A00

// File: filelist.f
common/isa_pkg.sv
common/core_pkg.sv
rtl/decode.sv
rename/rename_table.sv
rob/rob.sv
rtl/arf.sv
rtl/operand_select.sv
rtl/dispatch.sv
dv/dispatch_checker.sv
dv/dispatch_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= dispatch_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f
PASS_MSG  ?= All checks passed

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) dv/dispatch_vectors.hex
	./$(SIM) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
